//--- drbg_seed_path.f
+incdir+hdl
hdl/seed_pkg.sv
hdl/dbg_ctrl_pkg.sv
hdl/dbg_load_fsm.sv
hdl/seed_bit_counter.sv
hdl/seed_shift_reg.sv
hdl/seed_output_stage.sv
hdl/drbg_seed_path.sv
testbench/tb_drbg_seed_path.sv

//--- Bender.yml
package:
  name: drbg_seed_path

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/seed_pkg.sv
      - hdl/dbg_ctrl_pkg.sv
      - hdl/dbg_load_fsm.sv
      - hdl/seed_bit_counter.sv
      - hdl/seed_shift_reg.sv
      - hdl/seed_output_stage.sv
      - hdl/drbg_seed_path.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/tb_drbg_seed_path.sv

//--- testbench/tb_drbg_seed_path.sv
// testbench with lfsr stimulus, cycle model of the seed path, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "drbg_seed_macros.svh"

module tb_drbg_seed_path;

  localparam int unsigned NUM_SCEN     = 40;
  localparam int unsigned MAX_DELAY    = 31;
  localparam int unsigned RESET_CYCLES = 2;
  // worst scenario covers a full load, the longest ready wait, stretch and gap
  localparam int unsigned SCEN_CYCLES  = 257 + MAX_DELAY + 8;
  localparam int unsigned CYCLE_LIMIT  = 2 * NUM_SCEN * SCEN_CYCLES + 16;
  localparam int unsigned VALID_WAIT   = MAX_DELAY + 4;
  // start cycle to first valid cycle with ready already up
  localparam int unsigned LOAD_LATENCY = `DRBG_SEED_BITS + 1;
  localparam int          M_IDLE       = 0;
  localparam int          M_SHIFT      = 1;
  localparam int          M_WAIT       = 2;

  // one cycle worth of DUT inputs
  typedef struct packed {
    logic                       rst_n;
    logic                       debug_mode;
    logic                       serial;
    logic                       start;
    logic                       ready;
    logic                       cond_valid;
    logic [`DRBG_SEED_BITS-1:0] cond_seed;
  } stim_t;

  logic            clk;
  logic            rst_n;
  logic            debug_mode;
  logic            serial_in;
  logic            load_start;
  logic            drbg_ready;
  logic            cond_valid;
  seed_pkg::seed_t cond_seed;
  seed_pkg::seed_t seed;
  logic            seed_valid;

  logic [31:0] lfsr_q    = 32'hc732;
  int unsigned cycle_cnt = 0;

  // reference model state
  int                         m_state;
  int                         m_bits;
  int                         m_valid_left;
  logic [`DRBG_SEED_BITS-1:0] m_shift;
  logic [`DRBG_SEED_BITS-1:0] m_captured;
  logic [`DRBG_SEED_BITS-1:0] m_seed;

  drbg_seed_path u_drbg_seed_path (
    .clk          (clk),
    .rst_n        (rst_n),
    .debug_mode_i (debug_mode),
    .serial_in_i  (serial_in),
    .load_start_i (load_start),
    .drbg_ready_i (drbg_ready),
    .cond_seed_i  (cond_seed),
    .cond_valid_i (cond_valid),
    .seed_o       (seed),
    .seed_valid_o (seed_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_value(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    abort_run();
  endtask

  // watchdog over the whole run
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  // galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit handed out
  function automatic logic rand_bit();
    lfsr_q = lfsr_next(lfsr_q);
    return lfsr_q[0];
  endfunction

  function automatic int unsigned rand_bits(input int unsigned n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | rand_bit();
    end
    return v;
  endfunction

  function automatic logic [`DRBG_SEED_BITS-1:0] rand_seed();
    logic [`DRBG_SEED_BITS-1:0] v;
    v = '0;
    for (int i = 0; i < `DRBG_SEED_BITS; i++) begin
      v = {v[`DRBG_SEED_BITS-2:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic stim_t quiet_stim(input logic mode, input logic ready);
    stim_t s;
    s            = '0;
    s.rst_n      = 1'b1;
    s.debug_mode = mode;
    s.ready      = ready;
    return s;
  endfunction

  // advance the model over the edge using the inputs of the ending cycle
  task automatic model_step();
    logic deliver;
    logic accept;
    if (!rst_n) begin
      m_state      = M_IDLE;
      m_bits       = 0;
      m_valid_left = 0;
      m_seed       = '0;
    end else begin
      deliver = (m_state == M_WAIT) && drbg_ready;
      accept  = (deliver || (cond_valid && drbg_ready && !debug_mode)) && (m_valid_left == 0);
      // events inside a running stretch are lost
      if (accept) begin
        m_seed       = deliver ? m_captured : cond_seed.raw;
        m_valid_left = `DRBG_VALID_STRETCH;
      end else if (m_valid_left != 0) begin
        m_valid_left = m_valid_left - 1;
      end
      case (m_state)
        M_IDLE: begin
          // start cycle already takes the first bit
          if (debug_mode && load_start) begin
            m_shift = {m_shift[`DRBG_SEED_BITS-2:0], serial_in};
            m_bits  = 1;
            m_state = M_SHIFT;
          end
        end
        M_SHIFT: begin
          m_shift = {m_shift[`DRBG_SEED_BITS-2:0], serial_in};
          m_bits  = m_bits + 1;
          if (m_bits == `DRBG_SEED_BITS) begin
            m_captured = m_shift;
            m_state    = M_WAIT;
          end
        end
        default: begin
          if (drbg_ready) begin
            m_state = M_IDLE;
          end
        end
      endcase
    end
  endtask

  task automatic check_outputs();
    assert (seed_valid === (m_valid_left != 0)) else
      fail_value($sformatf("seed_valid_o is %b, model expects %b", seed_valid,
                           m_valid_left != 0));
    assert (seed.raw === m_seed) else
      fail_value($sformatf("seed_o is %h, model expects %h", seed.raw, m_seed));
  endtask

  // drive on the rising edge and compare on the falling one
  task automatic drive_cycle(input stim_t s);
    @(posedge clk);
    model_step();
    rst_n      <= s.rst_n;
    debug_mode <= s.debug_mode;
    serial_in  <= s.serial;
    load_start <= s.start;
    drbg_ready <= s.ready;
    cond_valid <= s.cond_valid;
    cond_seed  <= s.cond_seed;
    @(negedge clk);
    check_outputs();
  endtask

  // hold the inputs until seed_valid_o shows up
  // n counts the cycles driven
  task automatic wait_valid(input stim_t s, output int unsigned n);
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen) begin
      drive_cycle(s);
      n    = n + 1;
      seen = seed_valid;
      if (!seen && n >= VALID_WAIT) begin
        $display("seed_valid_o did not rise within %0d cycles of waiting", VALID_WAIT);
        abort_run();
      end
    end
  endtask

  task automatic run_debug_load(input logic ready_early);
    stim_t                      s;
    logic [`DRBG_SEED_BITS-1:0] bits;
    int unsigned                delay;
    int unsigned                extra_at;
    int unsigned                drop_at;
    int unsigned                n;
    int unsigned                latency;
    bits     = '0;
    delay    = ready_early ? 0 : rand_bits(5);
    extra_at = 1 + (rand_bits(8) % (`DRBG_SEED_BITS - 1));
    drop_at  = 1 + (rand_bits(8) % (`DRBG_SEED_BITS - 1));
    s        = quiet_stim(1'b1, ready_early);
    for (int i = 0; i < `DRBG_SEED_BITS; i++) begin
      s.serial = rand_bit();
      bits     = {bits[`DRBG_SEED_BITS-2:0], s.serial};
      // stray start mid-shift on slow-ready runs
      s.start  = (i == 0) || (!ready_early && i == extra_at);
      // load keeps going after the mode drops
      if (!ready_early && i == drop_at) begin
        s.debug_mode = 1'b0;
      end
      drive_cycle(s);
    end
    s.start  = 1'b0;
    s.serial = 1'b0;
    // ready held low in WAIT_READY
    for (int d = 0; d < delay; d++) begin
      drive_cycle(s);
    end
    s.ready = 1'b1;
    wait_valid(s, n);
    latency = (`DRBG_SEED_BITS - 1) + delay + n;
    assert (latency == LOAD_LATENCY + delay) else
      fail_value($sformatf("debug load latency %0d, expected %0d", latency,
                           LOAD_LATENCY + delay));
    assert (seed.raw === bits) else
      fail_value($sformatf("debug seed %h, shifted bits %h", seed.raw, bits));
    assert (seed.fields.key === bits[`DRBG_SEED_BITS-1:`DRBG_KEY_BITS]) else
      fail_value("key field differs from the upper half of the shifted bits");
    assert (seed.fields.v === bits[`DRBG_SEED_BITS-`DRBG_KEY_BITS-1:0]) else
      fail_value("V field differs from the lower half of the shifted bits");
    s.ready = rand_bit();
    drive_cycle(s);
    assert (seed_valid === 1'b1) else fail_value("debug seed_valid_o ended after one cycle");
    drive_cycle(s);
    assert (seed_valid === 1'b0) else fail_value("debug seed_valid_o ran past two cycles");
  endtask

  task automatic run_cond_accept();
    stim_t                      s;
    logic [`DRBG_SEED_BITS-1:0] first;
    logic                       late;
    first        = rand_seed();
    late         = rand_bit();
    s            = quiet_stim(1'b0, 1'b1);
    s.cond_valid = 1'b1;
    s.cond_seed  = first;
    drive_cycle(s);
    // a second strobe in E+1 or E+2 must be dropped
    s.cond_seed  = rand_seed();
    s.cond_valid = !late;
    drive_cycle(s);
    assert (seed_valid === 1'b1 && seed.raw === first) else
      fail_value("conditioner seed not presented in E+1");
    s.cond_valid = late;
    drive_cycle(s);
    assert (seed_valid === 1'b1 && seed.raw === first) else
      fail_value("conditioner seed not held in E+2");
    s.cond_valid = 1'b0;
    drive_cycle(s);
    assert (seed_valid === 1'b0 && seed.raw === first) else
      fail_value("strobe during the stretch was not dropped");
  endtask

  task automatic run_cond_ignored();
    stim_t                      s;
    logic [`DRBG_SEED_BITS-1:0] held;
    logic                       mode_high;
    held      = m_seed;
    mode_high = rand_bit();
    // debug mode up with ready high or ready low with debug off
    s            = quiet_stim(mode_high, mode_high);
    s.cond_valid = 1'b1;
    s.cond_seed  = rand_seed();
    drive_cycle(s);
    s.cond_valid = 1'b0;
    repeat (2) begin
      drive_cycle(s);
      assert (seed_valid === 1'b0 && seed.raw === held) else
        fail_value("unqualified conditioner strobe produced a seed");
    end
  endtask

  task automatic run_start_ignored();
    stim_t s;
    // ready stays up so a load started by mistake would hand over
    s        = quiet_stim(1'b0, 1'b1);
    s.start  = 1'b1;
    s.serial = rand_bit();
    drive_cycle(s);
    s.start = 1'b0;
    // watch past the cycle where such a load would show seed_valid_o
    repeat (LOAD_LATENCY + 1) begin
      drive_cycle(s);
      assert (seed_valid === 1'b0) else fail_value("start with debug mode low gave a seed");
    end
  endtask

  initial begin
    stim_t       s;
    int unsigned kind;
    rst_n      = 1'b0;
    debug_mode = 1'b0;
    serial_in  = 1'b0;
    load_start = 1'b0;
    drbg_ready = 1'b0;
    cond_valid = 1'b0;
    cond_seed  = '0;
    s          = quiet_stim(1'b0, 1'b0);
    // reset seen low on the first two edges
    for (int i = 0; i < RESET_CYCLES; i++) begin
      s.rst_n = (i == RESET_CYCLES - 1);
      drive_cycle(s);
    end
    repeat (4) begin
      drive_cycle(s);
      assert (seed_valid === 1'b0 && seed.raw === '0) else
        fail_value("outputs not cleared after reset");
    end
    // every kind once and then a random mix
    for (int scen = 0; scen < NUM_SCEN; scen++) begin
      kind = (scen < 5) ? scen : (rand_bits(3) % 5);
      case (kind)
        0: run_debug_load(1'b1);
        1: run_debug_load(1'b0);
        2: run_cond_accept();
        3: run_cond_ignored();
        default: run_start_ignored();
      endcase
      repeat (3) begin
        drive_cycle(quiet_stim(rand_bit(), rand_bit()));
      end
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/drbg_seed_path.sv
// drbg_seed_path: top level joining the debug loader and the seed output stage
`timescale 1ns/1ps
`default_nettype none

module drbg_seed_path (
  input  logic            clk,
  input  logic            rst_n,
  // debug path enable, level
  input  logic            debug_mode_i,
  // serial seed bits, one per clock
  input  logic            serial_in_i,
  // single-cycle start of a debug load
  input  logic            load_start_i,
  // wrapper wants a seed, level
  input  logic            drbg_ready_i,
  // conditioner seed and strobe
  input  seed_pkg::seed_t cond_seed_i,
  input  logic            cond_valid_i,
  // seed to the wrapper, valid for two cycles
  output seed_pkg::seed_t seed_o,
  output logic            seed_valid_o
);

  dbg_ctrl_pkg::dbg_ctrl_t ctrl;
  logic                    last;
  seed_pkg::seed_t         dbg_seed;

  // sequencer for the serial loader
  dbg_load_fsm u_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .debug_mode_i (debug_mode_i),
    .load_start_i (load_start_i),
    .drbg_ready_i (drbg_ready_i),
    .last_i       (last),
    .ctrl_o       (ctrl)
  );

  // shift enable doubles as the count increment
  seed_bit_counter u_cnt (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear_i (ctrl.cnt_clear),
    .inc_i   (ctrl.shift_en),
    .last_o  (last)
  );

  seed_shift_reg u_sreg (
    .clk       (clk),
    .rst_n     (rst_n),
    .serial_i  (serial_in_i),
    .shift_i   (ctrl.shift_en),
    .capture_i (ctrl.capture),
    .seed_o    (dbg_seed)
  );

  // conditioner goes straight in, debug via deliver
  seed_output_stage u_out (
    .clk           (clk),
    .rst_n         (rst_n),
    .debug_mode_i  (debug_mode_i),
    .drbg_ready_i  (drbg_ready_i),
    .cond_valid_i  (cond_valid_i),
    .cond_seed_i   (cond_seed_i),
    .dbg_deliver_i (ctrl.deliver),
    .dbg_seed_i    (dbg_seed),
    .seed_o        (seed_o),
    .seed_valid_o  (seed_valid_o)
  );

endmodule

`default_nettype wire

//--- hdl/seed_output_stage.sv
// seed_output_stage: event source select, seed register and two-cycle valid stretch
`timescale 1ns/1ps
`default_nettype none

`include "drbg_seed_macros.svh"

module seed_output_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            debug_mode_i,
  input  logic            drbg_ready_i,
  // conditioner strobe and its seed
  input  logic            cond_valid_i,
  input  seed_pkg::seed_t cond_seed_i,
  // debug loader request and its captured seed
  input  logic            dbg_deliver_i,
  input  seed_pkg::seed_t dbg_seed_i,
  output seed_pkg::seed_t seed_o,
  output logic            seed_valid_o
);

  localparam int unsigned STRETCH = `DRBG_VALID_STRETCH;
  localparam int unsigned STR_W   = $clog2(STRETCH + 1);

  logic             cond_evt;
  logic             busy;
  logic             accept;
  logic [STR_W-1:0] stretch_q;
  seed_pkg::seed_t  seed_q;

  // conditioner only counts with the wrapper ready and debug off
  assign cond_evt = cond_valid_i && drbg_ready_i && !debug_mode_i;

  // any stretch in progress masks new events
  assign busy   = (stretch_q != '0);
  assign accept = (cond_evt || dbg_deliver_i) && !busy;

  // loaded on accept, counts down to zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stretch_q <= '0;
    end else if (accept) begin
      stretch_q <= STR_W'(STRETCH);
    end else if (busy) begin
      stretch_q <= stretch_q - 1'b1;
    end
  end

  // debug wins if both fire on the same cycle
  // seed holds until the next accepted event
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seed_q <= '0;
    end else if (accept) begin
      seed_q <= dbg_deliver_i ? dbg_seed_i : cond_seed_i;
    end
  end

  assign seed_o       = seed_q;
  // high for E+1 and E+2
  assign seed_valid_o = busy;

  // valid window never runs longer than the stretch
  a_valid_len : assert property (
    @(posedge clk) disable iff (!rst_n)
    seed_valid_o [*STRETCH] |=> !seed_valid_o
  );

  // wrapper may sample on either valid cycle
  a_seed_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (seed_valid_o && $past(seed_valid_o)) |-> $stable(seed_o)
  );

endmodule

`default_nettype wire

//--- hdl/seed_shift_reg.sv
// seed_shift_reg: serial-in shift register with capture of the finished seed
`timescale 1ns/1ps
`default_nettype none

`include "drbg_seed_macros.svh"

module seed_shift_reg (
  input  logic            clk,
  input  logic            rst_n,
  // serial data, one bit per clock
  input  logic            serial_i,
  input  logic            shift_i,
  // last bit this cycle, latch the full word
  input  logic            capture_i,
  output seed_pkg::seed_t seed_o
);

  logic [`DRBG_SEED_BITS-1:0] shift_q;
  logic [`DRBG_SEED_BITS-1:0] shift_next;
  seed_pkg::seed_t            seed_q;

  // left shift, first bit in ends up at the msb after 256 shifts
  assign shift_next = {shift_q[`DRBG_SEED_BITS-2:0], serial_i};

  always_ff @(posedge clk) begin
    if (shift_i) begin
      shift_q <= shift_next;
    end
  end

  // capture takes the current bit too
  // seed is complete the cycle after capture
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seed_q <= '0;
    end else if (capture_i) begin
      seed_q.raw <= shift_next;
    end
  end

  assign seed_o = seed_q;

  // capture comes with the final shift, then shifting stops
  a_capture_ends_shift : assert property (
    @(posedge clk) disable iff (!rst_n)
    capture_i |-> shift_i ##1 !shift_i
  );

endmodule

`default_nettype wire

//--- hdl/seed_bit_counter.sv
// seed_bit_counter: counts shifted serial bits and flags the last one
`timescale 1ns/1ps
`default_nettype none

`include "drbg_seed_macros.svh"

module seed_bit_counter (
  input  logic clk,
  input  logic rst_n,
  // hold count at zero
  input  logic clear_i,
  // one bit shifted this cycle
  input  logic inc_i,
  // count is on the final bit
  output logic last_o
);

  localparam logic [`DRBG_BIT_CNT_W-1:0] CNT_MAX = `DRBG_BIT_CNT_W'(`DRBG_SEED_BITS - 1);

  logic [`DRBG_BIT_CNT_W-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (inc_i && (cnt_q != CNT_MAX)) begin
      // saturates on the last bit, cleared later in WAIT_READY
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // comb on the count so capture lines up with bit 255
  assign last_o = (cnt_q == CNT_MAX);

  // the FSM must stop shifting right after the last bit
  // otherwise the count would have to wrap
  a_no_inc_past_max : assert property (
    @(posedge clk) disable iff (!rst_n)
    (inc_i && last_o) |=> !inc_i
  );

endmodule

`default_nettype wire

//--- hdl/dbg_load_fsm.sv
// dbg_load_fsm: debug loader sequencer through idle, shift and wait-for-ready
`timescale 1ns/1ps
`default_nettype none

module dbg_load_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  // debug enable, only looked at on the start cycle
  input  logic                    debug_mode_i,
  // single-cycle start pulse
  input  logic                    load_start_i,
  // wrapper wants a seed
  input  logic                    drbg_ready_i,
  // bit counter sits on the last bit
  input  logic                    last_i,
  output dbg_ctrl_pkg::dbg_ctrl_t ctrl_o
);

  dbg_ctrl_pkg::dbg_state_e state_q;
  dbg_ctrl_pkg::dbg_state_e state_d;
  logic                     start;

  // start only counts with debug mode up
  // outside IDLE the pulse is never looked at
  assign start = debug_mode_i && load_start_i;

  always_comb begin
    state_d = state_q;
    ctrl_o  = '0;
    case (state_q)
      dbg_ctrl_pkg::IDLE: begin
        // start cycle is shift cycle 0, first bit goes in on this edge
        if (start) begin
          ctrl_o.shift_en = 1'b1;
          state_d         = dbg_ctrl_pkg::SHIFT;
        end
      end
      dbg_ctrl_pkg::SHIFT: begin
        // one bit per clock until the counter reports the last one
        ctrl_o.shift_en = 1'b1;
        if (last_i) begin
          // bit 255 goes straight into the captured seed
          ctrl_o.capture = 1'b1;
          state_d        = dbg_ctrl_pkg::WAIT_READY;
        end
      end
      dbg_ctrl_pkg::WAIT_READY: begin
        // park the counter at zero for the next load
        ctrl_o.cnt_clear = 1'b1;
        // hand over on the first ready cycle, back to idle next edge
        if (drbg_ready_i) begin
          ctrl_o.deliver = 1'b1;
          state_d        = dbg_ctrl_pkg::IDLE;
        end
      end
      default: begin
        state_d = dbg_ctrl_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= dbg_ctrl_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // shifting and handing over belong to different phases of a load
  a_no_shift_with_deliver : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ctrl_o.shift_en && ctrl_o.deliver)
  );

endmodule

`default_nettype wire

//--- hdl/dbg_ctrl_pkg.sv
// debug loader control types: FSM state enum and control strobe struct
`default_nettype none

package dbg_ctrl_pkg;

  // debug loader states
  // IDLE waits for a start, SHIFT takes 256 bits, WAIT_READY holds the seed
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    SHIFT      = 2'd1,
    WAIT_READY = 2'd2
  } dbg_state_e;

  // strobes from the FSM to the datapath blocks
  typedef struct packed {
    // shift one serial bit, also counts it
    logic shift_en;
    // hold the bit count at zero
    logic cnt_clear;
    // latch the finished seed
    logic capture;
    // single-cycle request to the output stage
    logic deliver;
  } dbg_ctrl_t;

endpackage

`default_nettype wire

//--- hdl/seed_pkg.sv
// seed data types: key/V field struct and raw/split seed union
`default_nettype none

`include "drbg_seed_macros.svh"

package seed_pkg;

  // wrapper view of a seed
  // key sits in the upper half, counter value V below it
  typedef struct packed {
    logic [`DRBG_KEY_BITS-1:0]                  key;
    logic [`DRBG_SEED_BITS-`DRBG_KEY_BITS-1:0]  v;
  } seed_fields_t;

  // one seed word, read either raw or as key/V
  // the loader writes raw, the wrapper reads fields
  typedef union packed {
    logic [`DRBG_SEED_BITS-1:0] raw;
    seed_fields_t               fields;
  } seed_t;

endpackage

`default_nettype wire

//--- hdl/drbg_seed_macros.svh
// width macros for the drbg seed path: seed, key, bit counter, valid stretch
`ifndef DRBG_SEED_MACROS_SVH
`define DRBG_SEED_MACROS_SVH

// full seed word handed to the wrapper
`define DRBG_SEED_BITS 256

// aes key width
// V takes whatever is left of the seed word
`define DRBG_KEY_BITS 128

// serial bit counter, counts 0 to 255
`define DRBG_BIT_CNT_W 8

// cycles that seed_valid_o stays high per accepted event
// matches the two-cycle strobe the wrapper expects
`define DRBG_VALID_STRETCH 2

`endif
